// File: llc_tag_store.f
+incdir+verification
src/llc_tag_cfg_pkg.sv
src/llc_tag_op_pkg.sv
src/llc_tag_req_decode.sv
src/llc_tag_way_array.sv
src/llc_tag_lookup_exec.sv
src/llc_tag_result_stage.sv
src/llc_tag_store.sv
verification/llc_tag_store_properties.sv
verification/llc_tag_store_tb.sv

// File: src/llc_tag_cfg_pkg.sv
// Tag store geometry and timing constants
// Geometry values are defaults for the top level parameters

package llc_tag_cfg_pkg;

  // Default set associativity
  parameter int NumWays = 4;

  // Default number of sets per way
  parameter int NumLines = 64;

  // Default width of a stored tag
  parameter int TagWidth = 20;

  // Default set index width, log2 of NumLines
  parameter int IndexWidth = 6;

  // Tag array read latency in cycles
  // Decode and execute timing is built around a single cycle read
  parameter int ArrayLatency = 1;

endpackage

// File: src/llc_tag_lookup_exec.sv
// Lookup and flush execute
// Hit detection, victim choice and the tag update write for one request
// Victim is the first free eligible way, else round robin over eligible ways

`timescale 1ns/1ps

module llc_tag_lookup_exec #(
  parameter int NumWays    = llc_tag_cfg_pkg::NumWays,
  parameter int TagWidth   = llc_tag_cfg_pkg::TagWidth,
  parameter int IndexWidth = llc_tag_cfg_pkg::IndexWidth
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             lookup_i,
  input  llc_tag_op_pkg::tag_mode_e        mode_i,
  input  logic [IndexWidth-1:0]            index_i,
  input  logic [TagWidth-1:0]              tag_i,
  input  logic                             dirty_i,
  input  logic [NumWays-1:0]               way_mask_i,
  input  logic [NumWays-1:0]               spm_lock_i,
  input  logic [NumWays-1:0][TagWidth-1:0] rd_tag_i,
  input  logic [NumWays-1:0]               rd_valid_i,
  input  logic [NumWays-1:0]               rd_dirty_i,
  output logic [NumWays-1:0]               wr_en_o,
  output logic [IndexWidth-1:0]            wr_index_o,
  output logic [TagWidth-1:0]              wr_tag_o,
  output logic                             wr_valid_o,
  output logic                             wr_dirty_o,
  output logic                             load_o,
  output logic                             hit_o,
  output logic [NumWays-1:0]               way_o,
  output logic                             evict_o,
  output logic [TagWidth-1:0]              evict_tag_o
);

  localparam int WayIdxW = (NumWays > 1) ? $clog2(NumWays) : 1;
  localparam int EntryW  = TagWidth + llc_tag_op_pkg::EntryFlagBits;
  localparam int VldPos  = TagWidth + llc_tag_op_pkg::EntryValidBit;
  localparam int DrtPos  = TagWidth + llc_tag_op_pkg::EntryDirtyBit;

  logic [NumWays-1:0][EntryW-1:0] entry;
  logic [NumWays-1:0]             hit, eligible;
  logic [NumWays-1:0]             hit_oh, flush_oh, victim_oh;
  logic [WayIdxW-1:0]             hit_idx, flush_idx, free_idx, rr_idx, victim_idx;
  logic [WayIdxW-1:0]             rr_q, rr_next;
  logic                           any_hit, free_any, rr_found, rr_step;
  logic [EntryW-1:0]              hit_entry, flush_entry, victim_entry;

  // Read data packed back into the stored entry layout
  for (genvar w = 0; w < NumWays; w++) begin : gen_entry
    assign entry[w] = {rd_valid_i[w], rd_dirty_i[w], rd_tag_i[w]};
    assign hit[w]   = way_mask_i[w] && rd_valid_i[w] && (rd_tag_i[w] == tag_i);
  end

  // Locked ways stay out of replacement
  assign eligible = way_mask_i & ~spm_lock_i;

  // Lowest set bit of each vector, scan runs downward so the lowest wins
  always_comb begin : proc_pick
    int cand;
    hit_idx   = '0;
    flush_idx = '0;
    free_idx  = '0;
    rr_idx    = '0;
    rr_found  = 1'b0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit[w]) hit_idx = WayIdxW'(w);
      if (way_mask_i[w]) flush_idx = WayIdxW'(w);
      if (eligible[w] && !rd_valid_i[w]) free_idx = WayIdxW'(w);
    end
    // First eligible way at or after the pointer, wrapping around
    for (int off = 0; off < NumWays; off++) begin
      cand = int'(rr_q) + off;
      if (cand >= NumWays) cand = cand - NumWays;
      if (!rr_found && eligible[cand]) begin
        rr_found = 1'b1;
        rr_idx   = WayIdxW'(cand);
      end
    end
  end

  assign any_hit    = |hit;
  assign free_any   = |(eligible & ~rd_valid_i);
  assign victim_idx = free_any ? free_idx : rr_idx;
  assign hit_oh     = any_hit ? (NumWays'(1) << hit_idx) : '0;
  assign flush_oh   = (|way_mask_i) ? (NumWays'(1) << flush_idx) : '0;
  // rr_found doubles as "some way is eligible"
  assign victim_oh  = rr_found ? (NumWays'(1) << victim_idx) : '0;

  assign hit_entry    = entry[hit_idx];
  assign flush_entry  = entry[flush_idx];
  assign victim_entry = entry[victim_idx];

  // Pointer only moves when round robin actually chose the victim
  assign rr_next = (rr_idx == WayIdxW'(NumWays - 1)) ? '0 : rr_idx + 1'b1;
  assign rr_step = lookup_i && (mode_i == llc_tag_op_pkg::Lookup) && !any_hit &&
                   !free_any && rr_found;

  always_ff @(posedge clk_i) begin : proc_rr
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (rr_step) begin
      rr_q <= rr_next;
    end
  end

  // Every lookup strobe produces a response
  assign load_o     = lookup_i;
  assign wr_index_o = index_i;

  always_comb begin : proc_result
    wr_en_o     = '0;
    wr_tag_o    = tag_i;
    wr_valid_o  = 1'b1;
    wr_dirty_o  = dirty_i;
    hit_o       = 1'b0;
    way_o       = '0;
    evict_o     = 1'b0;
    evict_tag_o = '0;
    if (lookup_i) begin
      if (mode_i == llc_tag_op_pkg::Flush) begin
        // Report the old entry, then clear it
        way_o       = flush_oh;
        evict_o     = flush_entry[VldPos] & flush_entry[DrtPos];
        evict_tag_o = evict_o ? flush_entry[TagWidth-1:0] : '0;
        wr_en_o     = flush_oh;
        wr_tag_o    = '0;
        wr_valid_o  = 1'b0;
        wr_dirty_o  = 1'b0;
      end else if (any_hit) begin
        hit_o = 1'b1;
        way_o = hit_oh;
        // Mark dirty only on a clean line
        if (dirty_i && !hit_entry[DrtPos]) wr_en_o = hit_oh;
      end else begin
        // Miss, zero way and no write when nothing is eligible
        way_o       = victim_oh;
        evict_o     = victim_entry[VldPos] & victim_entry[DrtPos] & rr_found;
        evict_tag_o = evict_o ? victim_entry[TagWidth-1:0] : '0;
        wr_en_o     = victim_oh;
      end
    end
  end

endmodule

// File: src/llc_tag_op_pkg.sv
// Tag store request modes and stored entry layout
// An entry is the tag with the flag bits placed above it

package llc_tag_op_pkg;

  // Request mode carried with every request
  typedef enum logic {
    Lookup = 1'b0,
    Flush  = 1'b1
  } tag_mode_e;

  // Flag positions, counted from the first bit above the tag field
  // Entry bit index is TagWidth plus the offset
  parameter int EntryDirtyBit = 0;

  // Valid flag sits on top of the entry
  parameter int EntryValidBit = 1;

  // Number of flag bits added to the tag width
  parameter int EntryFlagBits = 2;

  // Layout of one entry, MSB first
  //   [valid][dirty][tag]

endpackage

// File: src/llc_tag_req_decode.sv
// Tag store request decode
// Takes one request, reads the tag array and hands the held request to execute

`timescale 1ns/1ps

module llc_tag_req_decode #(
  parameter int NumWays    = llc_tag_cfg_pkg::NumWays,
  parameter int TagWidth   = llc_tag_cfg_pkg::TagWidth,
  parameter int IndexWidth = llc_tag_cfg_pkg::IndexWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  input  llc_tag_op_pkg::tag_mode_e req_mode_i,
  input  logic [IndexWidth-1:0]     req_index_i,
  input  logic [TagWidth-1:0]       req_tag_i,
  input  logic                      req_dirty_i,
  input  logic [NumWays-1:0]        req_way_mask_i,
  input  logic                      out_full_i,
  input  logic                      done_i,
  output logic                      req_ready_o,
  output logic                      rd_en_o,
  output logic [IndexWidth-1:0]     rd_index_o,
  output logic                      lookup_o,
  output llc_tag_op_pkg::tag_mode_e mode_o,
  output logic [IndexWidth-1:0]     index_o,
  output logic [TagWidth-1:0]       tag_o,
  output logic                      dirty_o,
  output logic [NumWays-1:0]        way_mask_o
);

  localparam int Lat = llc_tag_cfg_pkg::ArrayLatency;

  logic                      busy_q;
  logic                      accept;
  logic [Lat-1:0]            rd_pipe_q;
  llc_tag_op_pkg::tag_mode_e mode_q;
  logic [IndexWidth-1:0]     index_q;
  logic [TagWidth-1:0]       tag_q;
  logic                      dirty_q;
  logic [NumWays-1:0]        mask_q;

  // Idle and nothing waiting in the response register
  assign req_ready_o = !busy_q && !out_full_i;
  assign accept      = req_valid_i && req_ready_o;

  // Array is read straight from the request port in the accept cycle
  assign rd_en_o    = accept;
  assign rd_index_o = req_index_i;

  // Busy from accept until execute has loaded the response
  always_ff @(posedge clk_i) begin : proc_busy
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      rd_pipe_q <= '0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      // Read token, lines up the lookup strobe with the array data
      rd_pipe_q <= (rd_pipe_q << 1) | Lat'(accept);
    end
  end

  // Request fields held for execute
  always_ff @(posedge clk_i) begin : proc_hold
    if (accept) begin
      mode_q  <= req_mode_i;
      index_q <= req_index_i;
      tag_q   <= req_tag_i;
      dirty_q <= req_dirty_i;
      mask_q  <= req_way_mask_i;
    end
  end

  assign lookup_o   = rd_pipe_q[Lat-1];
  assign mode_o     = mode_q;
  assign index_o    = index_q;
  assign tag_o      = tag_q;
  assign dirty_o    = dirty_q;
  assign way_mask_o = mask_q;

endmodule

// File: src/llc_tag_result_stage.sv
// Tag store response register
// One entry, filled on load and emptied by the output handshake

`timescale 1ns/1ps

module llc_tag_result_stage #(
  parameter int TagWidth = 20,
  parameter int NumWays  = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                load_i,
  input  logic                hit_i,
  input  logic [NumWays-1:0]  way_i,
  input  logic                evict_i,
  input  logic [TagWidth-1:0] evict_tag_i,
  input  logic                res_ready_i,
  output logic                full_o,
  output logic                res_valid_o,
  output logic                res_hit_o,
  output logic [NumWays-1:0]  res_way_o,
  output logic                res_evict_o,
  output logic [TagWidth-1:0] res_evict_tag_o
);

  logic                full_q;
  logic                hit_q;
  logic [NumWays-1:0]  way_q;
  logic                evict_q;
  logic [TagWidth-1:0] evict_tag_q;

  // Full from load until the response is taken
  // Load wins, though decode never lets both happen together
  always_ff @(posedge clk_i) begin : proc_full
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (load_i) begin
      full_q <= 1'b1;
    end else if (full_q && res_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload, held stable while waiting for ready
  always_ff @(posedge clk_i) begin : proc_payload
    if (load_i) begin
      hit_q       <= hit_i;
      way_q       <= way_i;
      evict_q     <= evict_i;
      evict_tag_q <= evict_tag_i;
    end
  end

  assign full_o          = full_q;
  assign res_valid_o     = full_q;
  assign res_hit_o       = hit_q;
  assign res_way_o       = way_q;
  assign res_evict_o     = evict_q;
  assign res_evict_tag_o = evict_tag_q;

endmodule

// File: src/llc_tag_store.sv
// LLC tag store top level
// Decode, per-way tag array, lookup execute and response register
// One request in flight, valid/ready on both request and response side

`timescale 1ns/1ps

module llc_tag_store #(
  parameter int NumWays    = llc_tag_cfg_pkg::NumWays,
  parameter int NumLines   = llc_tag_cfg_pkg::NumLines,
  parameter int TagWidth   = llc_tag_cfg_pkg::TagWidth,
  parameter int IndexWidth = llc_tag_cfg_pkg::IndexWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request port
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  llc_tag_op_pkg::tag_mode_e req_mode_i,
  input  logic [IndexWidth-1:0]     req_index_i,
  input  logic [TagWidth-1:0]       req_tag_i,
  input  logic                      req_dirty_i,
  input  logic [NumWays-1:0]        req_way_mask_i,
  // Scratchpad locked ways, never used as victims
  input  logic [NumWays-1:0]        spm_lock_i,
  // Response port
  output logic                      res_valid_o,
  input  logic                      res_ready_i,
  output logic                      res_hit_o,
  output logic [NumWays-1:0]        res_way_o,
  output logic                      res_evict_o,
  output logic [TagWidth-1:0]       res_evict_tag_o
);

  // Decode to array read side
  logic                           rd_en;
  logic [IndexWidth-1:0]          rd_index;
  // Array read data, one cycle after rd_en
  logic [NumWays-1:0][TagWidth-1:0] rd_tag;
  logic [NumWays-1:0]             rd_valid;
  logic [NumWays-1:0]             rd_dirty;
  // Held request towards execute
  logic                           lookup;
  llc_tag_op_pkg::tag_mode_e      mode;
  logic [IndexWidth-1:0]          index;
  logic [TagWidth-1:0]            tag;
  logic                           dirty;
  logic [NumWays-1:0]             way_mask;
  // Execute update write
  logic [NumWays-1:0]             wr_en;
  logic [IndexWidth-1:0]          wr_index;
  logic [TagWidth-1:0]            wr_tag;
  logic                           wr_valid;
  logic                           wr_dirty;
  // Execute to result stage
  logic                           load;
  logic                           hit;
  logic [NumWays-1:0]             way;
  logic                           evict;
  logic [TagWidth-1:0]            evict_tag;
  logic                           out_full;

  llc_tag_req_decode #(
    .NumWays    (NumWays),
    .TagWidth   (TagWidth),
    .IndexWidth (IndexWidth)
  ) i_decode (
    .clk_i, .rst_n_i, .req_valid_i, .req_mode_i, .req_index_i, .req_tag_i, .req_dirty_i,
    .req_way_mask_i, .out_full_i(out_full), .done_i(load), .req_ready_o,
    .rd_en_o(rd_en), .rd_index_o(rd_index), .lookup_o(lookup), .mode_o(mode),
    .index_o(index), .tag_o(tag), .dirty_o(dirty), .way_mask_o(way_mask)
  );

  llc_tag_way_array #(
    .NumWays    (NumWays),
    .NumLines   (NumLines),
    .TagWidth   (TagWidth),
    .IndexWidth (IndexWidth)
  ) i_way_array (
    .clk_i, .rst_n_i, .rd_en_i(rd_en), .rd_index_i(rd_index), .wr_en_i(wr_en),
    .wr_index_i(wr_index), .wr_tag_i(wr_tag), .wr_valid_i(wr_valid), .wr_dirty_i(wr_dirty),
    .rd_tag_o(rd_tag), .rd_valid_o(rd_valid), .rd_dirty_o(rd_dirty)
  );

  llc_tag_lookup_exec #(
    .NumWays    (NumWays),
    .TagWidth   (TagWidth),
    .IndexWidth (IndexWidth)
  ) i_exec (
    .clk_i, .rst_n_i, .lookup_i(lookup), .mode_i(mode), .index_i(index), .tag_i(tag),
    .dirty_i(dirty), .way_mask_i(way_mask), .spm_lock_i, .rd_tag_i(rd_tag),
    .rd_valid_i(rd_valid), .rd_dirty_i(rd_dirty), .wr_en_o(wr_en), .wr_index_o(wr_index),
    .wr_tag_o(wr_tag), .wr_valid_o(wr_valid), .wr_dirty_o(wr_dirty), .load_o(load),
    .hit_o(hit), .way_o(way), .evict_o(evict), .evict_tag_o(evict_tag)
  );

  llc_tag_result_stage #(
    .TagWidth (TagWidth),
    .NumWays  (NumWays)
  ) i_result (
    .clk_i, .rst_n_i, .load_i(load), .hit_i(hit), .way_i(way), .evict_i(evict),
    .evict_tag_i(evict_tag), .res_ready_i, .full_o(out_full), .res_valid_o, .res_hit_o,
    .res_way_o, .res_evict_o, .res_evict_tag_o
  );

endmodule

// File: src/llc_tag_way_array.sv
// Per-way tag array
// One memory per way holds tags and dirty flags
// Valid flags sit in registers cleared by reset
// All ways of a set are read together with one cycle latency

`timescale 1ns/1ps

module llc_tag_way_array #(
  parameter int NumWays    = llc_tag_cfg_pkg::NumWays,
  parameter int NumLines   = llc_tag_cfg_pkg::NumLines,
  parameter int TagWidth   = llc_tag_cfg_pkg::TagWidth,
  parameter int IndexWidth = llc_tag_cfg_pkg::IndexWidth
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             rd_en_i,
  input  logic [IndexWidth-1:0]            rd_index_i,
  input  logic [NumWays-1:0]               wr_en_i,
  input  logic [IndexWidth-1:0]            wr_index_i,
  input  logic [TagWidth-1:0]              wr_tag_i,
  input  logic                             wr_valid_i,
  input  logic                             wr_dirty_i,
  output logic [NumWays-1:0][TagWidth-1:0] rd_tag_o,
  output logic [NumWays-1:0]               rd_valid_o,
  output logic [NumWays-1:0]               rd_dirty_o
);

  // Memory word ends at the dirty flag of the entry layout
  localparam int DrtPos = TagWidth + llc_tag_op_pkg::EntryDirtyBit;
  localparam int MemW   = DrtPos + 1;

  logic [MemW-1:0] wr_entry;

  // Write word, same for every way, wr_en_i picks the way
  always_comb begin : proc_wr_entry
    wr_entry                 = '0;
    wr_entry[TagWidth-1:0]   = wr_tag_i;
    wr_entry[DrtPos]         = wr_dirty_i;
  end

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    logic [MemW-1:0]     mem_q [NumLines];
    logic [MemW-1:0]     rd_entry_q;
    logic [NumLines-1:0] valid_q;
    logic                rd_vld_q;

    // Tag and dirty storage, no reset
    always_ff @(posedge clk_i) begin : proc_mem
      if (wr_en_i[w]) begin
        mem_q[wr_index_i] <= wr_entry;
      end
      if (rd_en_i) begin
        rd_entry_q <= mem_q[rd_index_i];
      end
    end

    // Valid flags cleared by reset so the array starts empty
    always_ff @(posedge clk_i) begin : proc_valid
      if (!rst_n_i) begin
        valid_q  <= '0;
        rd_vld_q <= 1'b0;
      end else begin
        if (wr_en_i[w]) begin
          valid_q[wr_index_i] <= wr_valid_i;
        end
        if (rd_en_i) begin
          rd_vld_q <= valid_q[rd_index_i];
        end
      end
    end

    assign rd_tag_o[w]   = rd_entry_q[TagWidth-1:0];
    assign rd_dirty_o[w] = rd_entry_q[DrtPos];
    assign rd_valid_o[w] = rd_vld_q;
  end

endmodule

// File: verification/llc_tag_store_properties.sv
// Handshake and response checks on the tag store top level
// Bound into every llc_tag_store instance

`timescale 1ns/1ps

module llc_tag_store_properties #(
  parameter int NumWays  = 4,
  parameter int TagWidth = 20
) (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                req_valid_i,
  input logic                req_ready_o,
  input logic                res_valid_o,
  input logic                res_ready_i,
  input logic                res_hit_o,
  input logic [NumWays-1:0]  res_way_o,
  input logic                res_evict_o,
  input logic [TagWidth-1:0] res_evict_tag_o
);

  // Number of failed assertions so far
  int fail_count = 0;

  // Response held while the consumer stalls
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o &&
    $stable({res_hit_o, res_way_o, res_evict_o, res_evict_tag_o}))
    else begin
      fail_count++;
      $error("response changed under back-pressure");
    end

  // Way is one-hot or zero
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> $onehot0(res_way_o))
    else begin
      fail_count++;
      $error("res_way_o has more than one bit set");
    end

  // No new request while a response waits
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o && !res_ready_i |-> !req_ready_o)
    else begin
      fail_count++;
      $error("req_ready_o high while a response is pending");
    end

  // Fixed response latency
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_o |-> ##2 $rose(res_valid_o))
    else begin
      fail_count++;
      $error("res_valid_o did not rise 2 cycles after accept");
    end

endmodule

bind llc_tag_store llc_tag_store_properties #(
  .NumWays  (NumWays),
  .TagWidth (TagWidth)
) i_properties (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .req_valid_i     (req_valid_i),
  .req_ready_o     (req_ready_o),
  .res_valid_o     (res_valid_o),
  .res_ready_i     (res_ready_i),
  .res_hit_o       (res_hit_o),
  .res_way_o       (res_way_o),
  .res_evict_o     (res_evict_o),
  .res_evict_tag_o (res_evict_tag_o)
);

// File: verification/llc_tag_store_model.svh
// Reference model of the tag store
// Mirrors valid, dirty and tag per way and set, plus the round robin pointer
// Included in the testbench module body, uses its parameters

`ifndef LLC_TAG_STORE_MODEL_SVH
`define LLC_TAG_STORE_MODEL_SVH

logic                m_valid [NumWays][NumLines];
logic                m_dirty [NumWays][NumLines];
logic [TagWidth-1:0] m_tag   [NumWays][NumLines];
int                  m_rr;

// Expected responses, oldest first
logic                exp_hit_q[$];
logic [NumWays-1:0]  exp_way_q[$];
logic                exp_evict_q[$];
logic [TagWidth-1:0] exp_evict_tag_q[$];

// Empty array and pointer at way 0, as after reset
task automatic model_reset();
  for (int w = 0; w < NumWays; w++) begin
    for (int s = 0; s < NumLines; s++) begin
      m_valid[w][s] = 1'b0;
      m_dirty[w][s] = 1'b0;
      m_tag[w][s]   = '0;
    end
  end
  m_rr = 0;
endtask

// Apply one accepted request and queue its expected response
task automatic model_apply(input logic is_flush, input int idx,
                           input logic [TagWidth-1:0] tag, input logic dirty,
                           input logic [NumWays-1:0] mask, input logic [NumWays-1:0] lock);
  int                  way;
  int                  pick;
  logic                hit;
  logic                evict;
  logic [TagWidth-1:0] evict_tag;
  way       = -1;
  hit       = 1'b0;
  evict     = 1'b0;
  evict_tag = '0;
  if (is_flush) begin
    // Flush targets the way named by the mask
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (mask[w]) way = w;
    end
  end else begin
    // Lowest masked valid way with an equal tag
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (mask[w] && m_valid[w][idx] && m_tag[w][idx] == tag) way = w;
    end
    hit = (way >= 0);
    if (!hit) begin
      // Lowest free unlocked way first
      for (int w = NumWays - 1; w >= 0; w--) begin
        if (mask[w] && !lock[w] && !m_valid[w][idx]) way = w;
      end
      // Else first unlocked masked way from the pointer on
      for (int k = 0; k < NumWays && way < 0; k++) begin
        pick = (m_rr + k) % NumWays;
        if (mask[pick] && !lock[pick]) begin
          way  = pick;
          m_rr = (pick + 1) % NumWays;
        end
      end
    end
  end
  if (way >= 0) begin
    if (!hit) begin
      evict     = m_valid[way][idx] && m_dirty[way][idx];
      evict_tag = evict ? m_tag[way][idx] : '0;
    end
    if (is_flush) begin
      m_valid[way][idx] = 1'b0;
      m_dirty[way][idx] = 1'b0;
      m_tag[way][idx]   = '0;
    end else if (hit) begin
      m_dirty[way][idx] = m_dirty[way][idx] | dirty;
    end else begin
      m_valid[way][idx] = 1'b1;
      m_dirty[way][idx] = dirty;
      m_tag[way][idx]   = tag;
    end
  end
  exp_hit_q.push_back(hit);
  exp_way_q.push_back((way >= 0) ? (NumWays'(1) << way) : '0);
  exp_evict_q.push_back(evict);
  exp_evict_tag_q.push_back(evict_tag);
endtask

`endif

// File: verification/llc_tag_store_tb.sv
// Testbench for the LLC tag store
// Random lookups and flushes over a few sets and tags, random back-pressure,
// responses checked against a reference model, watchdog on the whole run

`timescale 1ns/1ps

module llc_tag_store_tb;

  localparam int NumWays    = llc_tag_cfg_pkg::NumWays;
  localparam int NumLines   = llc_tag_cfg_pkg::NumLines;
  localparam int TagWidth   = llc_tag_cfg_pkg::TagWidth;
  localparam int IndexWidth = llc_tag_cfg_pkg::IndexWidth;
  localparam int NumReqs    = 400;
  // Budget per request covers idle gaps and stalls
  localparam int TimeoutNs  = NumReqs * 40 + 200;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  llc_tag_op_pkg::tag_mode_e req_mode_i;
  logic [IndexWidth-1:0]     req_index_i;
  logic [TagWidth-1:0]       req_tag_i;
  logic                      req_dirty_i;
  logic [NumWays-1:0]        req_way_mask_i;
  logic [NumWays-1:0]        spm_lock_i;
  logic                      res_valid_o;
  logic                      res_ready_i;
  logic                      res_hit_o;
  logic [NumWays-1:0]        res_way_o;
  logic                      res_evict_o;
  logic [TagWidth-1:0]       res_evict_tag_o;

  integer              seed;
  int                  errors;
  int                  sent;
  int                  received;
  int                  cyc = 0;
  int                  accept_cyc;
  logic                accepted;
  logic                resp_seen;
  logic                held_hit;
  logic [NumWays-1:0]  held_way;
  logic                held_evict;
  logic [TagWidth-1:0] held_evict_tag;

  `include "llc_tag_store_model.svh"

  llc_tag_store #(
    .NumWays    (NumWays),
    .NumLines   (NumLines),
    .TagWidth   (TagWidth),
    .IndexWidth (IndexWidth)
  ) uut (
    .clk_i, .rst_n_i, .req_valid_i, .req_ready_o, .req_mode_i, .req_index_i, .req_tag_i,
    .req_dirty_i, .req_way_mask_i, .spm_lock_i, .res_valid_o, .res_ready_i, .res_hit_o,
    .res_way_o, .res_evict_o, .res_evict_tag_o
  );

  always #2 clk_i = ~clk_i;

  // Rising edges seen so far
  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s actual %0h expected %0h", $time, name, actual,
               expected);
    end
  endtask

  // New random request, small index and tag ranges so sets fill up
  task automatic drive_request();
    req_mode_i  = (($unsigned($random(seed)) % 5) == 0) ? llc_tag_op_pkg::Flush :
                  llc_tag_op_pkg::Lookup;
    req_index_i = IndexWidth'($unsigned($random(seed)) % 2);
    req_tag_i   = TagWidth'($unsigned($random(seed)) % 6);
    req_dirty_i = 1'($random(seed));
    if (req_mode_i == llc_tag_op_pkg::Flush) begin
      req_way_mask_i = NumWays'(1) << ($unsigned($random(seed)) % NumWays);
    end else if (1'($random(seed))) begin
      req_way_mask_i = '1;
    end else begin
      req_way_mask_i = NumWays'($random(seed));
    end
    // Locks held from accept until the lookup is done
    spm_lock_i  = (($unsigned($random(seed)) % 4) == 0) ? NumWays'($random(seed)) : '0;
    req_valid_i = 1'b1;
  endtask

  // Called between edges, where handshake signals are stable
  task automatic observe();
    if (req_valid_i && req_ready_o) begin
      model_apply(req_mode_i == llc_tag_op_pkg::Flush, int'(req_index_i), req_tag_i,
                  req_dirty_i, req_way_mask_i, spm_lock_i);
      accept_cyc = cyc;
      accepted   = 1'b1;
      sent++;
    end
    if (res_valid_o) begin
      check_value("req_ready_o", req_ready_o, 1'b0);
      if (exp_hit_q.size() == 0) begin
        errors++;
        $display("Response at %0t ns with no request outstanding", $time);
      end else if (!resp_seen) begin
        check_value("res_valid_o latency", cyc - accept_cyc, 2);
        check_value("res_hit_o", res_hit_o, exp_hit_q[0]);
        check_value("res_way_o", res_way_o, exp_way_q[0]);
        check_value("res_evict_o", res_evict_o, exp_evict_q[0]);
        check_value("res_evict_tag_o", res_evict_tag_o, exp_evict_tag_q[0]);
        held_hit       = res_hit_o;
        held_way       = res_way_o;
        held_evict     = res_evict_o;
        held_evict_tag = res_evict_tag_o;
        resp_seen      = 1'b1;
      end else begin
        check_value("res_hit_o", res_hit_o, held_hit);
        check_value("res_way_o", res_way_o, held_way);
        check_value("res_evict_o", res_evict_o, held_evict);
        check_value("res_evict_tag_o", res_evict_tag_o, held_evict_tag);
      end
      // Taken at the coming edge
      if (res_ready_i && exp_hit_q.size() > 0) begin
        void'(exp_hit_q.pop_front());
        void'(exp_way_q.pop_front());
        void'(exp_evict_q.pop_front());
        void'(exp_evict_tag_q.pop_front());
        resp_seen = 1'b0;
        received++;
      end
    end
  endtask

  initial begin : stimulus
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_mode_i     = llc_tag_op_pkg::Lookup;
    req_index_i    = '0;
    req_tag_i      = '0;
    req_dirty_i    = 1'b0;
    req_way_mask_i = '0;
    spm_lock_i     = '0;
    res_ready_i    = 1'b0;
    seed           = 32'h50f06525;
    errors         = 0;
    sent           = 0;
    received       = 0;
    accept_cyc     = 0;
    accepted       = 1'b0;
    resp_seen      = 1'b0;
    model_reset();
    repeat (2) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("req_ready_o", req_ready_o, 1'b1);
    check_value("res_valid_o", res_valid_o, 1'b0);
    while (received < NumReqs) begin
      @(posedge clk_i);
      #1;
      res_ready_i = ($unsigned($random(seed)) % 3) != 0;
      if (accepted) begin
        req_valid_i = 1'b0;
        accepted    = 1'b0;
      end else if (!req_valid_i && sent < NumReqs && ($unsigned($random(seed)) % 4) != 0) begin
        drive_request();
      end
      @(negedge clk_i);
      observe();
    end
    // Failed bound assertions count as errors too
    errors += uut.i_properties.fail_count;
    $display("Errors: %0d, of which assertions: %0d, sent: %0d, checked: %0d", errors,
             uut.i_properties.fail_count, sent, received);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("Timeout after %0d ns with %0d of %0d responses received", TimeoutNs,
             received, NumReqs);
    $display("Test failed");
    $finish;
  end

endmodule
